/* common/gather_pkg.sv */
package gather_pkg;

    localparam int word_bytes = 4;   // bytes per memory word
    localparam int buf_words  = 4;   // words per buffer
    localparam int ptr_w      = 4;
    localparam int idx_w      = $clog2(buf_words);
    localparam int addr_w     = ptr_w + idx_w;
    localparam int size_w     = 8;
    localparam int meta_w     = 4;
    localparam int burst_w    = $clog2(buf_words + 1);   // 0..buf_words

    typedef logic [ptr_w-1:0]  ptr_t;
    typedef logic [addr_w-1:0] addr_t;   // {ptr, word index}
    typedef logic [size_w-1:0] pkt_size_t;
    typedef logic [meta_w-1:0] meta_t;

    typedef enum logic [2:0] {
        st_ok        = 3'd0,
        st_err_desc  = 3'd1,
        st_err_chain = 3'd2,
        st_err_len   = 3'd3
    } status_t;

    typedef struct packed {
        pkt_size_t size;
        status_t   status;
    } event_t;

endpackage : gather_pkg

/* common/gather_if.sv */
`timescale 1ns/1ps

interface desc_if import gather_pkg::*; ();

    logic      valid;
    logic      rdy;
    ptr_t      ptr;   // first buffer of the chain
    pkt_size_t size;
    logic      err;
    meta_t     meta;

    modport source (output valid, ptr, size, err, meta, input rdy);
    modport sink   (input valid, ptr, size, err, meta, output rdy);

endinterface : desc_if

interface chain_if import gather_pkg::*; ();

    logic req;
    ptr_t ptr;
    logic ack;       // one cycle, one cycle after req
    ptr_t nxt_ptr;
    logic last;      // no buffer after this one

    modport master (output req, ptr, input ack, nxt_ptr, last);
    modport slave  (input req, ptr, output ack, nxt_ptr, last);

endinterface : chain_if

interface rd_if import gather_pkg::*; ();

    logic               burst_valid;
    logic               burst_rdy;
    addr_t              burst_addr;
    logic [burst_w-1:0] burst_words;   // zero means error word only
    logic               burst_last;
    logic               done;          // last word of last burst delivered

    modport master (
        output burst_valid, burst_addr, burst_words, burst_last,
        input  burst_rdy, done
    );
    modport slave (
        input  burst_valid, burst_addr, burst_words, burst_last,
        output burst_rdy, done
    );

endinterface : rd_if

/* gather/desc_fifo.sv */
`timescale 1ns/1ps

module desc_fifo import gather_pkg::*; #(
    parameter int fifo_depth = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    output logic      in_rdy,
    input  ptr_t      in_ptr,
    input  pkt_size_t in_size,
    input  logic      in_err,
    input  meta_t     in_meta,
    desc_if.source    out
);

    localparam int aw = $clog2(fifo_depth);
    localparam int cw = $clog2(fifo_depth + 1);

    ptr_t      f_ptr  [fifo_depth];
    pkt_size_t f_size [fifo_depth];
    logic      f_err  [fifo_depth];
    meta_t     f_meta [fifo_depth];

    logic [aw-1:0] wr_idx;
    logic [aw-1:0] rd_idx;
    logic [cw-1:0] count;   // occupancy
    logic          wr_en;
    logic          rd_en;

    assign in_rdy    = (count != cw'(fifo_depth));
    assign out.valid = (count != '0);
    assign wr_en     = in_valid && in_rdy;
    assign rd_en     = out.valid && out.rdy;

    assign out.ptr  = f_ptr[rd_idx];
    assign out.size = f_size[rd_idx];
    assign out.err  = f_err[rd_idx];
    assign out.meta = f_meta[rd_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_idx <= (wr_idx == aw'(fifo_depth - 1)) ? '0 : wr_idx + 1'b1;
            end
            if (rd_en) begin
                rd_idx <= (rd_idx == aw'(fifo_depth - 1)) ? '0 : rd_idx + 1'b1;
            end
            count <= count + cw'(wr_en) - cw'(rd_en);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            f_ptr[wr_idx]  <= in_ptr;
            f_size[wr_idx] <= in_size;
            f_err[wr_idx]  <= in_err;
            f_meta[wr_idx] <= in_meta;
        end
    end

    // both sides meet only when the queue is empty or full
    assert property (@(posedge clk) disable iff (rst)
        (count == '0 || count == cw'(fifo_depth)) |-> wr_idx == rd_idx);

endmodule : desc_fifo

/* gather/chain_walker.sv */
`timescale 1ns/1ps

module chain_walker import gather_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    desc_if.sink      desc,
    chain_if.master   chain,
    rd_if.master      rd,
    output meta_t     cur_meta,
    output pkt_size_t cur_size,
    output status_t   cur_status,
    output logic      busy
);

    localparam logic [1:0] s_idle   = 2'd0;
    localparam logic [1:0] s_lookup = 2'd1;
    localparam logic [1:0] s_burst  = 2'd2;
    localparam logic [1:0] s_wait   = 2'd3;

    logic [1:0]         state;
    ptr_t               cur_ptr;
    ptr_t               nxt_q;
    pkt_size_t          remaining;   // bytes not yet covered by a burst
    logic [burst_w-1:0] words_q;
    logic               last_q;
    meta_t              meta_q;
    pkt_size_t          size_q;
    status_t            status_q;
    logic [size_w:0]    rem_words;

    assign rem_words = ({1'b0, remaining} + (size_w + 1)'(word_bytes - 1)) >> idx_w;

    assign desc.rdy       = (state == s_idle);
    assign chain.req      = (state == s_lookup);
    assign chain.ptr      = cur_ptr;
    assign rd.burst_valid = (state == s_burst);
    assign rd.burst_addr  = {cur_ptr, {idx_w{1'b0}}};
    assign rd.burst_words = words_q;
    assign rd.burst_last  = last_q;
    assign cur_meta       = meta_q;
    assign cur_size       = size_q;
    assign cur_status     = status_q;
    assign busy           = (state != s_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle: if (desc.valid) begin
                    state <= (desc.err || desc.size == '0) ? s_burst : s_lookup;
                end
                s_lookup: if (chain.ack) state <= s_burst;
                s_burst: if (rd.burst_rdy) state <= last_q ? s_wait : s_lookup;
                s_wait: if (rd.done) state <= s_idle;
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && desc.valid) begin
            cur_ptr   <= desc.ptr;
            remaining <= desc.size;
            meta_q    <= desc.meta;
            size_q    <= desc.size;
            words_q   <= '0;     // error word without reads
            last_q    <= 1'b1;
            if (desc.err) status_q <= st_err_desc;
            else if (desc.size == '0) status_q <= st_err_len;
            else status_q <= st_ok;
        end
        if (state == s_lookup && chain.ack) begin
            nxt_q   <= chain.nxt_ptr;
            words_q <= (rem_words > buf_words) ? burst_w'(buf_words) : burst_w'(rem_words);
            last_q  <= (rem_words <= buf_words) || chain.last;
            if (chain.last && rem_words > buf_words) status_q <= st_err_chain;   // chain too short
        end
        if (state == s_burst && rd.burst_rdy) begin
            cur_ptr   <= nxt_q;
            remaining <= remaining - pkt_size_t'(word_bytes * buf_words);
        end
    end

    // empty bursts only carry a failed descriptor
    assert property (@(posedge clk) disable iff (rst)
        rd.burst_valid && rd.burst_words == '0 |-> status_q != st_ok);

endmodule : chain_walker

/* gather/read_engine.sv */
`timescale 1ns/1ps

module read_engine import gather_pkg::*; #(
    parameter int max_outstanding = 2
) (
    input  logic        clk,
    input  logic        rst,
    rd_if.slave         rd,
    output logic        mem_req,
    output addr_t       mem_addr,
    input  logic [31:0] mem_data,
    input  logic        mem_ack,
    output logic        word_valid,
    output logic [31:0] word_data,
    output logic        word_last,
    input  logic [1:0]  credit
);

    localparam int cnt_w = $clog2(max_outstanding + 1);

    logic               active;
    addr_t              addr_q;
    logic [burst_w-1:0] left_q;
    logic               last_q;
    logic               empty_q;
    logic [cnt_w-1:0]   inflight;
    logic               pend_zero;   // stand-in word for an empty burst
    logic               pend_last;
    logic               issue;

    // reads in flight plus words held by the framer
    assign issue = active && (int'(inflight) + int'(credit) < max_outstanding);

    assign rd.burst_rdy = !active;
    assign rd.done      = word_last;
    assign mem_req      = issue && !empty_q;
    assign mem_addr     = addr_q;
    assign word_valid   = mem_ack || pend_zero;
    assign word_data    = pend_zero ? '0 : mem_data;
    assign word_last    = word_valid && pend_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            inflight  <= '0;
            pend_zero <= 1'b0;
            pend_last <= 1'b0;
        end else begin
            if (rd.burst_valid && !active) active <= 1'b1;
            else if (issue && left_q == burst_w'(1)) active <= 1'b0;
            pend_zero <= issue && empty_q;
            pend_last <= issue && last_q && left_q == burst_w'(1);
            inflight  <= inflight + cnt_w'(issue) - cnt_w'(word_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (rd.burst_valid && !active) begin
            addr_q  <= rd.burst_addr;
            left_q  <= (rd.burst_words == '0) ? burst_w'(1) : rd.burst_words;
            last_q  <= rd.burst_last;
            empty_q <= (rd.burst_words == '0);
        end else if (issue) begin
            addr_q <= addr_q + 1'b1;
            left_q <= left_q - 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) mem_ack |-> inflight != '0);

endmodule : read_engine

/* gather/packet_framer.sv */
`timescale 1ns/1ps

module packet_framer import gather_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        word_valid,
    input  logic [31:0] word_data,
    input  logic        word_last,
    output logic [1:0]  credit,
    input  meta_t       cur_meta,
    input  pkt_size_t   cur_size,
    input  status_t     cur_status,
    output logic        pkt_valid,
    input  logic        pkt_rdy,
    output logic [31:0] pkt_data,
    output logic        pkt_eop,
    output logic [1:0]  pkt_mty,
    output logic        pkt_err,
    output meta_t       pkt_meta,
    output logic        evt_valid,
    output event_t      evt
);

    logic [31:0] q_data   [2];
    logic        q_last   [2];
    meta_t       q_meta   [2];
    pkt_size_t   q_size   [2];   // kept per entry as the next packet may follow closely
    status_t     q_status [2];

    logic       head;
    logic [1:0] count;
    logic       wr_idx;
    logic       fire;
    logic [1:0] rem_bytes;

    assign fire   = pkt_valid && pkt_rdy;
    assign wr_idx = head ^ count[0];
    assign credit = count;

    assign pkt_valid = (count != '0);
    assign pkt_data  = q_data[head];
    assign pkt_eop   = q_last[head];
    assign pkt_meta  = q_meta[head];
    assign rem_bytes = 2'(q_size[head] % word_bytes);
    assign pkt_mty   = (pkt_eop && rem_bytes != '0) ? 2'(word_bytes - rem_bytes) : '0;
    assign pkt_err   = pkt_eop && (q_status[head] != st_ok);

    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= 1'b0;
            count     <= '0;
            evt_valid <= 1'b0;
        end else begin
            if (fire) head <= ~head;
            count     <= count + 2'(word_valid) - 2'(fire);
            evt_valid <= fire && pkt_eop;   // cycle after eop transfer
        end
    end

    always_ff @(posedge clk) begin
        if (word_valid) begin
            q_data[wr_idx]   <= word_data;
            q_last[wr_idx]   <= word_last;
            q_meta[wr_idx]   <= cur_meta;
            q_size[wr_idx]   <= cur_size;
            q_status[wr_idx] <= cur_status;
        end
        if (fire && pkt_eop) begin
            evt.size   <= q_size[head];
            evt.status <= q_status[head];
        end
    end

endmodule : packet_framer

/* hdl/buffer_store.sv */
`timescale 1ns/1ps

module buffer_store import gather_pkg::*; (
    input  logic        clk,
    input  logic        load_en,
    input  addr_t       load_addr,
    input  logic [31:0] load_data,
    input  logic        load_nxt_ptr_en,
    input  ptr_t        load_nxt_ptr,
    input  logic        load_last,
    chain_if.slave      chain,
    input  logic        mem_req,
    input  addr_t       mem_addr,
    output logic [31:0] mem_data,
    output logic        mem_ack
);

    localparam int n_bufs = 2 ** ptr_w;

    logic [31:0] mem      [n_bufs * buf_words];
    ptr_t        tbl_nxt  [n_bufs];
    logic        tbl_last [n_bufs];

    ptr_t load_buf;

    assign load_buf = load_addr[addr_w-1 -: ptr_w];   // table entry of the addressed buffer

    always_ff @(posedge clk) begin
        if (load_en) mem[load_addr] <= load_data;
        if (load_nxt_ptr_en) begin
            tbl_nxt[load_buf]  <= load_nxt_ptr;
            tbl_last[load_buf] <= load_last;
        end
    end

    always_ff @(posedge clk) begin
        chain.ack     <= chain.req && !chain.ack;   // one ack per lookup
        chain.nxt_ptr <= tbl_nxt[chain.ptr];
        chain.last    <= tbl_last[chain.ptr];
        mem_ack       <= mem_req;
        mem_data      <= mem[mem_addr];
    end

endmodule : buffer_store

/* hdl/packet_gather_top.sv */
`timescale 1ns/1ps

module packet_gather_top import gather_pkg::*; #(
    parameter int fifo_depth      = 4,
    parameter int max_outstanding = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        desc_valid,
    output logic        desc_rdy,
    input  ptr_t        desc_ptr,
    input  pkt_size_t   desc_size,
    input  logic        desc_err,
    input  meta_t       desc_meta,
    input  logic        load_en,
    input  addr_t       load_addr,
    input  logic [31:0] load_data,
    input  logic        load_nxt_ptr_en,
    input  ptr_t        load_nxt_ptr,
    input  logic        load_last,
    output logic        pkt_valid,
    input  logic        pkt_rdy,
    output logic [31:0] pkt_data,
    output logic        pkt_eop,
    output logic [1:0]  pkt_mty,
    output logic        pkt_err,
    output meta_t       pkt_meta,
    output logic        evt_valid,
    output pkt_size_t   evt_size,
    output status_t     evt_status
);

    desc_if  desc_bus ();
    chain_if chain_bus ();
    rd_if    rd_bus ();

    logic        mem_req;
    addr_t       mem_addr;
    logic [31:0] mem_data;
    logic        mem_ack;
    logic        word_valid;
    logic [31:0] word_data;
    logic        word_last;
    logic [1:0]  credit;
    meta_t       cur_meta;
    pkt_size_t   cur_size;
    status_t     cur_status;
    event_t      evt;

    assign evt_size   = evt.size;
    assign evt_status = evt.status;

    desc_fifo #(.fifo_depth(fifo_depth)) i_desc_fifo (
        .clk, .rst,
        .in_valid (desc_valid),
        .in_rdy   (desc_rdy),
        .in_ptr   (desc_ptr),
        .in_size  (desc_size),
        .in_err   (desc_err),
        .in_meta  (desc_meta),
        .out      (desc_bus.source)
    );

    chain_walker i_chain_walker (
        .clk, .rst,
        .desc       (desc_bus.sink),
        .chain      (chain_bus.master),
        .rd         (rd_bus.master),
        .cur_meta, .cur_size, .cur_status,
        .busy       ()
    );

    read_engine #(.max_outstanding(max_outstanding)) i_read_engine (
        .clk, .rst,
        .rd (rd_bus.slave),
        .mem_req, .mem_addr, .mem_data, .mem_ack,
        .word_valid, .word_data, .word_last, .credit
    );

    packet_framer i_packet_framer (
        .clk, .rst,
        .word_valid, .word_data, .word_last, .credit,
        .cur_meta, .cur_size, .cur_status,
        .pkt_valid, .pkt_rdy, .pkt_data, .pkt_eop, .pkt_mty, .pkt_err, .pkt_meta,
        .evt_valid, .evt
    );

    buffer_store i_buffer_store (
        .clk,
        .load_en, .load_addr, .load_data, .load_nxt_ptr_en, .load_nxt_ptr, .load_last,
        .chain (chain_bus.slave),
        .mem_req, .mem_addr, .mem_data, .mem_ack
    );

endmodule : packet_gather_top

/* verif/tb_gather.sv */
`timescale 1ns/1ps

module tb_gather import gather_pkg::*; ();

    logic        clk;
    logic        rst;
    logic        desc_valid;
    logic        desc_rdy;
    ptr_t        desc_ptr;
    pkt_size_t   desc_size;
    logic        desc_err;
    meta_t       desc_meta;
    logic        load_en;
    addr_t       load_addr;
    logic [31:0] load_data;
    logic        load_nxt_ptr_en;
    ptr_t        load_nxt_ptr;
    logic        load_last;
    logic        pkt_valid;
    logic        pkt_rdy;
    logic [31:0] pkt_data;
    logic        pkt_eop;
    logic [1:0]  pkt_mty;
    logic        pkt_err;
    meta_t       pkt_meta;
    logic        evt_valid;
    pkt_size_t   evt_size;
    status_t     evt_status;

    logic [31:0] mem_model  [64];   // what was loaded into the buffer memory
    ptr_t        nxt_model  [16];
    logic        last_model [16];
    logic [31:0] exp_q [$];         // words of the packet being collected

    packet_gather_top #(.fifo_depth(4), .max_outstanding(2)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic load_buffer(input ptr_t p, input ptr_t nxt, input logic last);
        logic [31:0] v;
        nxt_model[p]  = nxt;
        last_model[p] = last;
        for (int i = 0; i < buf_words; i++) begin
            v = $urandom();
            mem_model[int'(p) * buf_words + i] = v;
            @(posedge clk);
            load_en         <= 1'b1;
            load_addr       <= addr_t'(int'(p) * buf_words + i);
            load_data       <= v;
            load_nxt_ptr_en <= (i == 0);   // table entry written once per buffer
            load_nxt_ptr    <= nxt;
            load_last       <= last;
        end
        @(posedge clk);
        load_en         <= 1'b0;
        load_nxt_ptr_en <= 1'b0;
    endtask

    // walks the loaded chain and queues the words the packet should carry
    function automatic status_t queue_expected(input ptr_t first, input pkt_size_t size);
        ptr_t p;
        int   left;
        p    = first;
        left = (int'(size) + word_bytes - 1) / word_bytes;
        while (left > 0) begin
            for (int i = 0; i < buf_words && left > 0; i++) begin
                exp_q.push_back(mem_model[int'(p) * buf_words + i]);
                left--;
            end
            if (left > 0 && last_model[p]) return st_err_chain;   // chain ran out
            p = nxt_model[p];
        end
        return st_ok;
    endfunction

    task automatic idle_after_reset();
        @(negedge clk);
        check_val("desc_rdy", 32'(desc_rdy), 32'd1);
        check_val("pkt_valid", 32'(pkt_valid), 32'd0);
        check_val("evt_valid", 32'(evt_valid), 32'd0);
    endtask

    task automatic send_desc(input ptr_t p, input pkt_size_t s, input logic e, input meta_t m);
        int t;
        @(posedge clk);
        desc_valid <= 1'b1;
        desc_ptr   <= p;
        desc_size  <= s;
        desc_err   <= e;
        desc_meta  <= m;
        t = 0;
        @(negedge clk);
        while (!desc_rdy) begin
            t++;
            if (t > 200) report_failure("timeout: desc_rdy never came back high");
            @(negedge clk);
        end
        @(posedge clk);   // transfer on this edge
        desc_valid <= 1'b0;
    endtask

    task automatic collect_packet(input meta_t m, input pkt_size_t size, input status_t st,
                                  input logic stall);
        int          t;
        logic        eop;
        logic [31:0] w;
        logic [1:0]  mty;
        mty = 2'((word_bytes - int'(size) % word_bytes) % word_bytes);
        eop = 1'b0;
        t   = 0;
        while (!eop) begin
            @(negedge clk);
            check_val("evt_valid", 32'(evt_valid), 32'd0);
            if (pkt_valid && pkt_rdy) begin
                if (exp_q.size() == 0) report_failure("output word past the packet length");
                w   = exp_q.pop_front();
                eop = (exp_q.size() == 0);
                check_val("pkt_data", pkt_data, w);
                check_val("pkt_eop", 32'(pkt_eop), 32'(eop));
                check_val("pkt_meta", 32'(pkt_meta), 32'(m));
                check_val("pkt_err", 32'(pkt_err), 32'(eop && st != st_ok));
                if (eop) check_val("pkt_mty", 32'(pkt_mty), 32'(mty));
                t = 0;
            end else begin
                t++;
                if (t > 200) report_failure("timeout waiting for an output word");
            end
            @(posedge clk);
            if (eop) pkt_rdy <= 1'b0;
            else if (stall) pkt_rdy <= ($urandom_range(0, 1) == 1);
            else pkt_rdy <= 1'b1;
        end
        @(negedge clk);   // event follows the eop transfer
        check_val("evt_valid", 32'(evt_valid), 32'd1);
        check_val("evt_size", 32'(evt_size), 32'(size));
        check_val("evt_status", 32'(evt_status), 32'(st));
    endtask

    task automatic single_buffer_packet();
        status_t st;
        load_buffer(4'd1, 4'd0, 1'b1);
        st = queue_expected(4'd1, 8'd10);
        send_desc(4'd1, 8'd10, 1'b0, 4'h3);
        collect_packet(4'h3, 8'd10, st, 1'b0);
    endtask

    task automatic three_buffer_chain();
        status_t st;
        load_buffer(4'd2, 4'd5, 1'b0);
        load_buffer(4'd5, 4'd9, 1'b0);
        load_buffer(4'd9, 4'd0, 1'b1);
        st = queue_expected(4'd2, 8'd40);
        send_desc(4'd2, 8'd40, 1'b0, 4'h7);
        collect_packet(4'h7, 8'd40, st, 1'b0);
    endtask

    task automatic errored_descriptor();
        exp_q.push_back(32'h0);   // lone zero word stands for the packet
        send_desc(4'd3, 8'd8, 1'b1, 4'h9);
        collect_packet(4'h9, 8'd8, st_err_desc, 1'b0);
    endtask

    task automatic short_chain_packet();
        status_t st;
        load_buffer(4'd10, 4'd11, 1'b0);
        load_buffer(4'd11, 4'd0, 1'b1);
        st = queue_expected(4'd10, 8'd40);
        send_desc(4'd10, 8'd40, 1'b0, 4'h5);
        collect_packet(4'h5, 8'd40, st, 1'b0);
    endtask

    task automatic random_backpressure();
        status_t st;
        st = queue_expected(4'd2, 8'd37);
        send_desc(4'd2, 8'd37, 1'b0, 4'hb);
        collect_packet(4'hb, 8'd37, st, 1'b1);
    endtask

    task automatic queue_fill_order();
        ptr_t      p [5] = '{4'd2, 4'd1, 4'd9, 4'd5, 4'd1};
        pkt_size_t s [5] = '{8'd40, 8'd12, 8'd16, 8'd20, 8'd4};
        status_t   st;
        // first one parks in the walker and the other four fill the queue
        for (int i = 0; i < 5; i++) begin
            send_desc(p[i], s[i], 1'b0, meta_t'(i + 1));
        end
        @(negedge clk);
        check_val("desc_rdy", 32'(desc_rdy), 32'd0);
        for (int i = 0; i < 5; i++) begin
            st = queue_expected(p[i], s[i]);
            collect_packet(meta_t'(i + 1), s[i], st, 1'b0);
        end
    endtask

    initial begin
        void'($urandom(32'hecc4_aa39));
        rst             = 1'b1;
        desc_valid      = 1'b0;
        desc_ptr        = '0;
        desc_size       = '0;
        desc_err        = 1'b0;
        desc_meta       = '0;
        load_en         = 1'b0;
        load_addr       = '0;
        load_data       = '0;
        load_nxt_ptr_en = 1'b0;
        load_nxt_ptr    = '0;
        load_last       = 1'b0;
        pkt_rdy         = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        idle_after_reset();
        single_buffer_packet();
        three_buffer_chain();
        errored_descriptor();
        short_chain_packet();
        random_backpressure();
        queue_fill_order();
        $display("Done: no errors");
        $finish;
    end

endmodule : tb_gather

/* build.f */
common/gather_pkg.sv
common/gather_if.sv
gather/desc_fifo.sv
gather/chain_walker.sv
gather/read_engine.sv
gather/packet_framer.sv
hdl/buffer_store.sv
hdl/packet_gather_top.sv
verif/tb_gather.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_gather -f build.f || exit 1
out="$(./obj_dir/Vtb_gather 2>&1)"
echo "$out"
echo "$out" | grep -q "Done: no errors" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
